// File: rtl/nird_pkg.sv
package nird_pkg;

  // frame geometry
  localparam int COLS = 12;
  localparam int ROWS = 10;

  localparam int COL_W = $clog2(COLS);
  localparam int ROW_W = $clog2(ROWS);

  // pixel and window sizes
  localparam int PIX_W   = 8;
  localparam int WIN_DIM = 5;
  localparam int WIN_PIX = WIN_DIM * WIN_DIM;

  // 25 pixels of 8 bits fit in 13 bits
  localparam int SUM_W = 13;

  // descriptor
  localparam int N_SAMPLES       = 8;
  localparam int CODE_W          = 4;
  localparam int RIU2_NONUNIFORM = 9;

  // mean compare without a divider, gain * sample >= sum
  localparam int GAIN = WIN_PIX;

  // line buffer, window, sampler, pattern, riu2
  localparam int PIPE_LAT = 4;

endpackage

// File: rtl/line_buffer.sv
`timescale 1ns/1ps

module line_buffer
  import nird_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [PIX_W-1:0]              pix_i,
  input  logic                          pix_valid_i,
  output logic [WIN_DIM-1:0][PIX_W-1:0] col_o,
  output logic                          col_valid_o
);

  // one row of storage for each older row of the window
  logic [PIX_W-1:0] row_mem [WIN_DIM-1][COLS];
  logic [COL_W-1:0] wr_ptr;

  // column pointer shared by all lines steps only on accepted pixels
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      col_valid_o <= 1'b0;
    end else begin
      col_valid_o <= pix_valid_i;
      if (pix_valid_i) begin
        if (wr_ptr == COL_W'(COLS - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  // each line hands its oldest pixel to the next one
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      col_o[0]           <= pix_i;
      row_mem[0][wr_ptr] <= pix_i;
      for (int k = 1; k < WIN_DIM - 1; k++) begin
        row_mem[k][wr_ptr] <= row_mem[k-1][wr_ptr];
      end
      // same column one to four rows back
      for (int k = 0; k < WIN_DIM - 1; k++) begin
        col_o[k+1] <= row_mem[k][wr_ptr];
      end
    end
  end

endmodule

// File: rtl/window_5x5.sv
`timescale 1ns/1ps

module window_5x5
  import nird_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [WIN_DIM-1:0][PIX_W-1:0]         col_i,
  input  logic                                  col_valid_i,
  output logic [WIN_PIX-1:0][PIX_W-1:0]         win_o,
  output logic                                  win_valid_o,
  output logic                                  win_last_o
);

  // position of the pixel that arrives with col_i
  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic             col_end;
  logic             row_end;
  logic             interior;

  assign col_end  = (col_cnt == COL_W'(COLS - 1));
  assign row_end  = (row_cnt == ROW_W'(ROWS - 1));

  // all 25 pixels inside the frame
  assign interior = (col_cnt >= COL_W'(WIN_DIM - 1)) &&
                    (row_cnt >= ROW_W'(WIN_DIM - 1));

  // raster counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (col_valid_i) begin
      if (col_end) begin
        col_cnt <= '0;
        if (row_end) begin
          row_cnt <= '0;
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // flags line up with the shifted window
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o <= 1'b0;
      win_last_o  <= 1'b0;
    end else begin
      win_valid_o <= col_valid_i && interior;
      win_last_o  <= col_valid_i && col_end && row_end;
    end
  end

  // row r counts from the top and column c from the left
  // newest column enters at the right edge with col_i[0] as the bottom row
  always_ff @(posedge clk) begin
    if (col_valid_i) begin
      for (int r = 0; r < WIN_DIM; r++) begin
        for (int c = 0; c < WIN_DIM - 1; c++) begin
          win_o[r*WIN_DIM + c] <= win_o[r*WIN_DIM + c + 1];
        end
        win_o[r*WIN_DIM + WIN_DIM - 1] <= col_i[WIN_DIM - 1 - r];
      end
    end
  end

  a_last_is_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    win_last_o |-> win_valid_o
  );

endmodule

// File: rtl/ring_sampler.sv
`timescale 1ns/1ps

module ring_sampler
  import nird_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [WIN_PIX-1:0][PIX_W-1:0]   win_i,
  input  logic                            win_valid_i,
  input  logic                            win_last_i,
  output logic [N_SAMPLES-1:0][PIX_W-1:0] s1_o,
  output logic [N_SAMPLES-1:0][PIX_W-1:0] s2_o,
  output logic [SUM_W-1:0]                sum_o,
  output logic                            valid_o,
  output logic                            last_o
);

  logic [N_SAMPLES-1:0][PIX_W-1:0] s1_d;
  logic [N_SAMPLES-1:0][PIX_W-1:0] s2_d;
  logic [SUM_W-1:0]                sum_d;

  // window index of row r, column c
  function automatic int idx(input int r, input int c);
    return r * WIN_DIM + c;
  endfunction

  // floor mean of a 2x2 block
  function automatic logic [PIX_W-1:0] avg4(input logic [PIX_W-1:0] a,
                                            input logic [PIX_W-1:0] b,
                                            input logic [PIX_W-1:0] c,
                                            input logic [PIX_W-1:0] d);
    logic [PIX_W+1:0] acc;
    acc = {2'b00, a} + {2'b00, b} + {2'b00, c} + {2'b00, d};
    return acc[PIX_W+1:2];
  endfunction

  // k * 45 deg counter-clockwise from the right, centre at (2,2)
  always_comb begin
    s1_d[0] = win_i[idx(2, 3)];
    s1_d[1] = win_i[idx(1, 3)];
    s1_d[2] = win_i[idx(1, 2)];
    s1_d[3] = win_i[idx(1, 1)];
    s1_d[4] = win_i[idx(2, 1)];
    s1_d[5] = win_i[idx(3, 1)];
    s1_d[6] = win_i[idx(3, 2)];
    s1_d[7] = win_i[idx(3, 3)];

    // axis samples two steps out, diagonals from the outer 2x2 blocks
    s2_d[0] = win_i[idx(2, 4)];
    s2_d[1] = avg4(win_i[idx(0, 3)], win_i[idx(0, 4)], win_i[idx(1, 3)], win_i[idx(1, 4)]);
    s2_d[2] = win_i[idx(0, 2)];
    s2_d[3] = avg4(win_i[idx(0, 0)], win_i[idx(0, 1)], win_i[idx(1, 0)], win_i[idx(1, 1)]);
    s2_d[4] = win_i[idx(2, 0)];
    s2_d[5] = avg4(win_i[idx(3, 0)], win_i[idx(3, 1)], win_i[idx(4, 0)], win_i[idx(4, 1)]);
    s2_d[6] = win_i[idx(4, 2)];
    s2_d[7] = avg4(win_i[idx(3, 3)], win_i[idx(3, 4)], win_i[idx(4, 3)], win_i[idx(4, 4)]);
  end

  // patch sum over the whole window
  always_comb begin
    sum_d = '0;
    for (int i = 0; i < WIN_PIX; i++) begin
      sum_d = sum_d + SUM_W'(win_i[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
      last_o  <= 1'b0;
    end else begin
      valid_o <= win_valid_i;
      last_o  <= win_last_i;
    end
  end

  // sample registers follow the window every cycle
  always_ff @(posedge clk) begin
    s1_o  <= s1_d;
    s2_o  <= s2_d;
    sum_o <= sum_d;
  end

endmodule

// File: rtl/riu2_map.sv
`timescale 1ns/1ps

module riu2_map
  import nird_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [N_SAMPLES-1:0] pattern_i,
  output logic [CODE_W-1:0]    code_o
);

  logic [CODE_W-1:0] n_trans;
  logic [CODE_W-1:0] n_ones;

  // transitions around the ring, bit 7 wraps back to bit 0
  always_comb begin
    n_trans = '0;
    n_ones  = '0;
    for (int k = 0; k < N_SAMPLES; k++) begin
      n_trans = n_trans + CODE_W'(pattern_i[k] ^ pattern_i[(k + 1) % N_SAMPLES]);
      n_ones  = n_ones + CODE_W'(pattern_i[k]);
    end
  end

  // uniform patterns keep their popcount
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_o <= '0;
    end else if (n_trans <= CODE_W'(2)) begin
      code_o <= n_ones;
    end else begin
      code_o <= CODE_W'(RIU2_NONUNIFORM);
    end
  end

  a_code_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    code_o <= CODE_W'(RIU2_NONUNIFORM)
  );

endmodule

// File: rtl/nird_code.sv
`timescale 1ns/1ps

module nird_code
  import nird_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [N_SAMPLES-1:0][PIX_W-1:0] s1_i,
  input  logic [N_SAMPLES-1:0][PIX_W-1:0] s2_i,
  input  logic [SUM_W-1:0]                sum_i,
  input  logic                            valid_i,
  input  logic                            last_i,
  output logic [CODE_W-1:0]               ni_o,
  output logic [CODE_W-1:0]               rd_o,
  output logic                            code_valid_o,
  output logic                            frame_done_o
);

  logic [N_SAMPLES-1:0] ni_pat;
  logic [N_SAMPLES-1:0] rd_pat;
  logic [N_SAMPLES-1:0] ni_pat_q;
  logic [N_SAMPLES-1:0] rd_pat_q;
  logic                 valid_q;
  logic                 last_q;

  // ni compares against the mean and rd against the inner ring
  always_comb begin
    for (int k = 0; k < N_SAMPLES; k++) begin
      ni_pat[k] = (SUM_W'(GAIN) * SUM_W'(s2_i[k])) >= sum_i;
      rd_pat[k] = s2_i[k] >= s1_i[k];
    end
  end

  always_ff @(posedge clk) begin
    ni_pat_q <= ni_pat;
    rd_pat_q <= rd_pat;
  end

  // two stages of flags to match the riu2 registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q      <= 1'b0;
      last_q       <= 1'b0;
      code_valid_o <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      valid_q      <= valid_i;
      last_q       <= last_i;
      code_valid_o <= valid_q;
      frame_done_o <= last_q;
    end
  end

  riu2_map ni_map_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pattern_i (ni_pat_q),
    .code_o    (ni_o)
  );

  riu2_map rd_map_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pattern_i (rd_pat_q),
    .code_o    (rd_o)
  );

  a_done_with_code: assert property (
    @(posedge clk) disable iff (!rst_n)
    frame_done_o |-> code_valid_o
  );

endmodule

// File: rtl/nird_r2.sv
`timescale 1ns/1ps

module nird_r2
  import nird_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [PIX_W-1:0]  pix_i,
  input  logic              pix_valid_i,
  output logic [CODE_W-1:0] ni_o,
  output logic [CODE_W-1:0] rd_o,
  output logic              code_valid_o,
  output logic              frame_done_o
);

  logic [WIN_DIM-1:0][PIX_W-1:0]   col;
  logic                            col_valid;
  logic [WIN_PIX-1:0][PIX_W-1:0]   win;
  logic                            win_valid;
  logic                            win_last;
  logic [N_SAMPLES-1:0][PIX_W-1:0] s1;
  logic [N_SAMPLES-1:0][PIX_W-1:0] s2;
  logic [SUM_W-1:0]                patch_sum;
  logic                            samp_valid;
  logic                            samp_last;

  line_buffer line_buffer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_i       (pix_i),
    .pix_valid_i (pix_valid_i),
    .col_o       (col),
    .col_valid_o (col_valid)
  );

  window_5x5 window_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .col_i       (col),
    .col_valid_i (col_valid),
    .win_o       (win),
    .win_valid_o (win_valid),
    .win_last_o  (win_last)
  );

  ring_sampler sampler_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .win_i       (win),
    .win_valid_i (win_valid),
    .win_last_i  (win_last),
    .s1_o        (s1),
    .s2_o        (s2),
    .sum_o       (patch_sum),
    .valid_o     (samp_valid),
    .last_o      (samp_last)
  );

  nird_code code_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .s1_i         (s1),
    .s2_i         (s2),
    .sum_i        (patch_sum),
    .valid_i      (samp_valid),
    .last_i       (samp_last),
    .ni_o         (ni_o),
    .rd_o         (rd_o),
    .code_valid_o (code_valid_o),
    .frame_done_o (frame_done_o)
  );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  // 8 ns period
  localparam realtime HALF_PERIOD = 4ns;

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

// File: verif/nird_r2_tb.sv
`timescale 1ns/1ps

module nird_r2_tb import nird_pkg::*; ();

  localparam int N_FRAMES        = 5;
  localparam int FLAT_FRAME      = 2;
  localparam int FIRST_GAP_FRAME = 3;
  localparam int RESET_CYCLES    = 10;
  localparam int EDGE            = WIN_DIM / 2;
  localparam int CODES_PER_FRAME = (COLS - 2 * EDGE) * (ROWS - 2 * EDGE);
  localparam int WATCHDOG_CYCLES = N_FRAMES * COLS * ROWS * 3 + 200;
  localparam logic [PIX_W-1:0] FLAT_PIX = 8'h5a;

  // unit steps for angle k, up is the previous row
  localparam int DX [N_SAMPLES] = '{1, 1, 0, -1, -1, -1, 0, 1};
  localparam int DY [N_SAMPLES] = '{0, -1, -1, -1, 0, 1, 1, 1};

  logic              clk;
  logic              rst_n;
  logic [PIX_W-1:0]  pix;
  logic              pix_valid;
  logic [CODE_W-1:0] ni;
  logic [CODE_W-1:0] rd;
  logic              code_valid;
  logic              frame_done;

  logic [PIX_W-1:0]  image [ROWS][COLS];
  logic [15:0]       lfsr_state;
  int                cycle = 0;
  int                acc_row = 0;
  int                acc_col = 0;
  int                acc_frame = 0;
  int                codes_in_frame = 0;
  int                frames_done = 0;
  int                value_errs = 0;
  int                timing_errs = 0;
  int                proto_errs = 0;

  // expected codes in output order
  logic [CODE_W-1:0] exp_ni_q [$];
  logic [CODE_W-1:0] exp_rd_q [$];
  int                exp_cyc_q [$];
  logic              exp_last_q [$];

  tb_clock clock_i (
    .clk_o (clk)
  );

  nird_r2 nird_r2_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pix_i        (pix),
    .pix_valid_i  (pix_valid),
    .ni_o         (ni),
    .rd_o         (rd),
    .code_valid_o (code_valid),
    .frame_done_o (frame_done)
  );

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [PIX_W-1:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[PIX_W-2:0], lfsr_state[0]};
    end
  endtask

  function automatic int px(input int r, input int c);
    return int'(image[r][c]);
  endfunction

  // uniform when the ring changes at most twice
  function automatic logic [CODE_W-1:0] riu2_ref(input logic [N_SAMPLES-1:0] p);
    logic [N_SAMPLES-1:0] rot;
    int changes;
    rot = {p[0], p[N_SAMPLES-1:1]};
    changes = $countones(p ^ rot);
    if (changes > 2) begin
      return CODE_W'(RIU2_NONUNIFORM);
    end else begin
      return CODE_W'($countones(p));
    end
  endfunction

  // ni code in the upper half, rd code in the lower half
  function automatic logic [2*CODE_W-1:0] ref_codes(input int cr, input int cc);
    int s1;
    int s2;
    int sum;
    logic [N_SAMPLES-1:0] ni_pat;
    logic [N_SAMPLES-1:0] rd_pat;
    sum = 0;
    for (int r = -EDGE; r <= EDGE; r++) begin
      for (int c = -EDGE; c <= EDGE; c++) begin
        sum += px(cr + r, cc + c);
      end
    end
    for (int k = 0; k < N_SAMPLES; k++) begin
      s1 = px(cr + DY[k], cc + DX[k]);
      if (DX[k] == 0 || DY[k] == 0) begin
        s2 = px(cr + 2 * DY[k], cc + 2 * DX[k]);
      end else begin
        s2 = (px(cr + DY[k], cc + DX[k]) + px(cr + DY[k], cc + 2 * DX[k]) +
              px(cr + 2 * DY[k], cc + DX[k]) + px(cr + 2 * DY[k], cc + 2 * DX[k])) / 4;
      end
      ni_pat[k] = (GAIN * s2 >= sum);
      rd_pat[k] = (s2 >= s1);
    end
    return {riu2_ref(ni_pat), riu2_ref(rd_pat)};
  endfunction

  task automatic check_code(input logic [CODE_W-1:0] got, input logic [CODE_W-1:0] exp,
                            input string name);
    if (got !== exp) begin
      value_errs++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_frame_done(input logic got, input logic exp);
    if (got !== exp) begin
      proto_errs++;
      $display("Error at %0t: frame_done_o is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_cycle(input int got, input int exp);
    if (got != exp) begin
      timing_errs++;
      $display("Error at %0t: code in cycle %0d, expected cycle %0d", $time, got, exp);
    end
  endtask

  // one raster frame, optional random idle cycles
  task automatic send_frame(input bit gaps, input bit flat);
    logic [PIX_W-1:0] bits;
    for (int i = 0; i < COLS * ROWS; i++) begin
      if (gaps) begin
        take_bits(1, bits);
        while (bits[0]) begin
          pix_valid <= 1'b0;
          @(posedge clk);
          take_bits(1, bits);
        end
      end
      take_bits(PIX_W, bits);
      pix       <= flat ? FLAT_PIX : bits;
      pix_valid <= 1'b1;
      @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // accepted pixels feed the model
  always @(posedge clk) begin
    logic [2*CODE_W-1:0] codes;
    if (rst_n && pix_valid) begin
      image[acc_row][acc_col] = pix;
      if (acc_row >= 2 * EDGE && acc_col >= 2 * EDGE) begin
        if (acc_frame == FLAT_FRAME) begin
          codes = {CODE_W'(N_SAMPLES), CODE_W'(N_SAMPLES)};
        end else begin
          codes = ref_codes(acc_row - EDGE, acc_col - EDGE);
        end
        exp_ni_q.push_back(codes[2*CODE_W-1:CODE_W]);
        exp_rd_q.push_back(codes[CODE_W-1:0]);
        exp_cyc_q.push_back(cycle + PIPE_LAT);
        exp_last_q.push_back(acc_row == ROWS - 1 && acc_col == COLS - 1);
      end
      if (acc_col == COLS - 1) begin
        acc_col = 0;
        if (acc_row == ROWS - 1) begin
          acc_row = 0;
          acc_frame++;
        end else begin
          acc_row++;
        end
      end else begin
        acc_col++;
      end
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n && (code_valid !== 1'b0 || frame_done !== 1'b0)) begin
      proto_errs++;
      $display("Error at %0t: outputs active while rst_n is low", $time);
    end
    if (code_valid === 1'b1) begin
      if (exp_ni_q.size() == 0) begin
        proto_errs++;
        $display("Error at %0t: code_valid_o high with no code expected", $time);
      end else begin
        check_code(ni, exp_ni_q.pop_front(), "ni_o");
        check_code(rd, exp_rd_q.pop_front(), "rd_o");
        check_cycle(cycle - 1, exp_cyc_q.pop_front());
        check_frame_done(frame_done, exp_last_q.pop_front());
        codes_in_frame++;
      end
      if (frame_done === 1'b1) begin
        if (codes_in_frame != CODES_PER_FRAME) begin
          proto_errs++;
          $display("Error at %0t: frame had %0d codes, expected %0d",
                   $time, codes_in_frame, CODES_PER_FRAME);
        end
        codes_in_frame = 0;
        frames_done++;
      end
    end else begin
      if (rst_n && code_valid !== 1'b0) begin
        proto_errs++;
        $display("Error at %0t: code_valid_o is unknown", $time);
      end
      if (frame_done !== 1'b0) begin
        proto_errs++;
        $display("Error at %0t: frame_done_o without code_valid_o", $time);
      end
      if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cycle - 1) begin
        proto_errs++;
        $display("Error at %0t: expected code for cycle %0d never came", $time, exp_cyc_q[0]);
        void'(exp_ni_q.pop_front());
        void'(exp_rd_q.pop_front());
        void'(exp_cyc_q.pop_front());
        void'(exp_last_q.pop_front());
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the DUT did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    lfsr_state = 16'd19;
    pix        = '0;
    pix_valid  = 1'b0;
    rst_n      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // frames follow each other without a pause
    for (int f = 0; f < N_FRAMES; f++) begin
      send_frame(f >= FIRST_GAP_FRAME, f == FLAT_FRAME);
    end
    pix_valid <= 1'b0;
    while (exp_ni_q.size() != 0 || frames_done < N_FRAMES) begin
      @(posedge clk);
    end
    // late or extra codes would show up here
    repeat (2 * PIPE_LAT) @(posedge clk);
    if (frames_done != N_FRAMES) begin
      proto_errs++;
      $display("Error at %0t: %0d frame ends seen, expected %0d", $time, frames_done, N_FRAMES);
    end
    $display("errors: value %0d, timing %0d, protocol %0d", value_errs, timing_errs, proto_errs);
    if (value_errs + timing_errs + proto_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: nird_r2.f
rtl/nird_pkg.sv
rtl/line_buffer.sv
rtl/window_5x5.sv
rtl/ring_sampler.sv
rtl/riu2_map.sv
rtl/nird_code.sv
rtl/nird_r2.sv
verif/tb_clock.sv
verif/nird_r2_tb.sv
